// File: Makefile
# Verilator build and run for the CSR unit testbench.

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

PASS_TEXT := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
source/riscv_isa_pkg.sv
source/csr_pkg.sv
source/sys_instr_decode.sv
source/csr_file.sv
source/trap_redirect.sv
source/csr_unit_top.sv
sim/csr_unit_tb.sv

// File: sim/csr_unit_tb.sv
`timescale 1ns/100ps
module csr_unit_tb;
    import riscv_isa_pkg::*;
    import csr_pkg::*;

    typedef struct {
        string    name;
        instr_t   instr;
        xlen_t    pc;
        xlen_t    rs1_value;
        int       gap;        // idle cycles after this entry.
        logic     wb_valid;
        reg_idx_t wb_rd;
        xlen_t    wb_value;
        logic     redir_valid;
        xlen_t    redir_target;
    } entry_t;

    typedef struct {
        int idx;
        int due;
    } pending_t;

    logic       I_sys_clk;
    logic       I_rst;
    sys_instr_t instr_in;
    csr_wb_t    wb;
    redirect_t  redirect;

    entry_t   table_q[$];
    pending_t pending_q[$];
    int       step_cnt;
    int       cycle_cnt;
    int       timeout_cycles;
    int       checks;
    int       errors;

    csr_unit_top u_dut (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .instr_in  (instr_in),
        .wb        (wb),
        .redirect  (redirect)
    );

    initial begin
        I_sys_clk = 1'b0;
    end

    always #2 I_sys_clk = ~I_sys_clk;

    always @(posedge I_sys_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic instr_t csr_word(input logic [2:0] funct3, input csr_addr_t addr,
                                        input reg_idx_t src, input reg_idx_t rd);
        instr_t w;
        w.funct12 = addr;
        w.rs1     = src;
        w.funct3  = funct3;
        w.rd      = rd;
        w.opcode  = OPCODE_SYSTEM;
        return w;
    endfunction

    function automatic instr_t priv_word(input logic [11:0] funct12);
        return csr_word(F3_PRIV, funct12, 5'd0, 5'd0);
    endfunction

    task automatic store_entry(input string name, input instr_t instr, input xlen_t pc,
                               input xlen_t rs1_value, input int gap, input logic wb_valid,
                               input xlen_t wb_value, input logic redir_valid,
                               input xlen_t redir_target);
        entry_t e;
        e.name         = name;
        e.instr        = instr;
        e.pc           = pc;
        e.rs1_value    = rs1_value;
        e.gap          = gap;
        e.wb_valid     = wb_valid;
        e.wb_rd        = instr.rd;
        e.wb_value     = wb_value;
        e.redir_valid  = redir_valid;
        e.redir_target = redir_target;
        table_q.push_back(e);
    endtask

    task automatic writeback_row(input string name, input instr_t instr, input xlen_t rs1_value,
                                 input int gap, input xlen_t value);
        store_entry(name, instr, 64'h8000_0000, rs1_value, gap, 1'b1, value, 1'b0, 64'h0);
    endtask

    task automatic redirect_row(input string name, input instr_t instr, input xlen_t pc,
                                input int gap, input xlen_t target);
        store_entry(name, instr, pc, 64'h0, gap, 1'b0, 64'h0, 1'b1, target);
    endtask

    task automatic silent_row(input string name, input instr_t instr, input xlen_t rs1_value,
                              input int gap);
        store_entry(name, instr, 64'h8000_0000, rs1_value, gap, 1'b0, 64'h0, 1'b0, 64'h0);
    endtask

    task automatic build_table();
        // reset values.
        writeback_row("rd_mstatus_rst", csr_word(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd5), 64'h0, 0,
                      64'ha_0000_1800);
        writeback_row("rd_mtvec_rst", csr_word(F3_CSRRS, CSR_MTVEC, 5'd0, 5'd5), 64'h0, 0, 64'h0);
        writeback_row("rd_mepc_rst", csr_word(F3_CSRRS, CSR_MEPC, 5'd0, 5'd5), 64'h0, 0, 64'h0);
        writeback_row("rd_mcause_rst", csr_word(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd5), 64'h0, 0,
                      64'h0);
        writeback_row("rd_mscratch_rst", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd5), 64'h0, 0,
                      64'h0);
        writeback_row("rd_unknown", csr_word(F3_CSRRS, 12'h7c0, 5'd0, 5'd5), 64'h0, 1, 64'h0);
        // read-modify-write chain, back to back.
        writeback_row("csrrw_mscratch", csr_word(F3_CSRRW, CSR_MSCRATCH, 5'd10, 5'd6),
                      64'h1234_5678_9abc_def0, 0, 64'h0);
        writeback_row("csrrw_mscratch_2", csr_word(F3_CSRRW, CSR_MSCRATCH, 5'd10, 5'd7),
                      64'h00ff_0000_0000_00f0, 0, 64'h1234_5678_9abc_def0);
        writeback_row("csrrs_mscratch", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd11, 5'd8),
                      64'h0000_0000_0000_0f0f, 0, 64'h00ff_0000_0000_00f0);
        writeback_row("csrrc_mscratch", csr_word(F3_CSRRC, CSR_MSCRATCH, 5'd12, 5'd9),
                      64'h00f0_0000_0000_000f, 0, 64'h00ff_0000_0000_0fff);
        writeback_row("rd_after_csrrc", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd9), 64'h0, 2,
                      64'h000f_0000_0000_0ff0);
        writeback_row("csrrwi_mscratch", csr_word(F3_CSRRWI, CSR_MSCRATCH, 5'h1f, 5'd10),
                      64'hdead_beef, 0, 64'h000f_0000_0000_0ff0);
        writeback_row("rd_after_csrrwi", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd10), 64'h0, 1,
                      64'h1f);
        // rd = x0 and zero source.
        silent_row("csrrw_rd0", csr_word(F3_CSRRW, CSR_MSCRATCH, 5'd13, 5'd0), 64'h5555, 0);
        writeback_row("rd_after_rd0", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd14),
                      64'hffff_0000_0000_0000, 0, 64'h5555);
        writeback_row("csrrsi_zero", csr_word(F3_CSRRSI, CSR_MSCRATCH, 5'd0, 5'd15), 64'hffff, 0,
                      64'h5555);
        writeback_row("rd_after_csrrsi0", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd15), 64'h0, 1,
                      64'h5555);
        // traps.
        writeback_row("wr_mtvec", csr_word(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd1), 64'h8000_0103, 0,
                      64'h0);
        redirect_row("ecall", priv_word(F12_ECALL), 64'h8000_1000, 0, 64'h8000_0100);
        writeback_row("rd_mepc_ecall", csr_word(F3_CSRRS, CSR_MEPC, 5'd0, 5'd2), 64'h0, 0,
                      64'h8000_1000);
        writeback_row("rd_mcause_ecall", csr_word(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd2), 64'h0, 0,
                      64'd11);
        redirect_row("ebreak", priv_word(F12_EBREAK), 64'h8000_2004, 0, 64'h8000_0100);
        writeback_row("rd_mepc_ebreak", csr_word(F3_CSRRS, CSR_MEPC, 5'd0, 5'd2), 64'h0, 0,
                      64'h8000_2004);
        writeback_row("rd_mcause_ebreak", csr_word(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd2), 64'h0, 0,
                      64'd3);
        writeback_row("rd_mstatus_trap", csr_word(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd2), 64'h0, 1,
                      64'ha_0000_1800);
        // mret with mie clear, mpie set.
        writeback_row("wr_mstatus", csr_word(F3_CSRRW, CSR_MSTATUS, 5'd3, 5'd3),
                      64'ha_0000_1880, 0, 64'ha_0000_1800);
        writeback_row("wr_mepc", csr_word(F3_CSRRW, CSR_MEPC, 5'd3, 5'd3), 64'h8000_3001, 0,
                      64'h8000_2004);
        redirect_row("mret", priv_word(F12_MRET), 64'h8000_4000, 0, 64'h8000_3000);
        writeback_row("rd_mstatus_mret", csr_word(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd4), 64'h0, 1,
                      64'ha_0000_1888);
        // dropped words.
        silent_row("non_system_addi", instr_t'(32'h0010_0093), 64'h1, 0);
        silent_row("system_funct3_100", csr_word(3'b100, CSR_MSCRATCH, 5'd1, 5'd5), 64'h1, 0);
        silent_row("priv_unknown", priv_word(12'h105), 64'h0, 0);
        writeback_row("rd_mscratch_final", csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd5), 64'h0, 0,
                      64'h5555);
    endtask

    task automatic compare_entry(input entry_t e);
        checks++;
        assert (wb.valid == e.wb_valid) else begin
            errors++;
            if (e.wb_valid) begin
                $display("%s: writeback strobe is missing", e.name);
            end else begin
                $display("%s: writeback strobe appeared but none was expected", e.name);
            end
        end
        assert (redirect.valid == e.redir_valid) else begin
            errors++;
            if (e.redir_valid) begin
                $display("%s: redirect strobe is missing", e.name);
            end else begin
                $display("%s: redirect strobe appeared but none was expected", e.name);
            end
        end
        if (wb.valid && e.wb_valid) begin
            assert (wb.rd == e.wb_rd) else begin
                errors++;
                $display("ERROR %s: rd expected %0d, actual %0d", e.name, e.wb_rd, wb.rd);
            end
            assert (wb.value == e.wb_value) else begin
                errors++;
                $display("ERROR %s: value expected 0x%h, actual 0x%h", e.name, e.wb_value,
                         wb.value);
            end
        end
        if (redirect.valid && e.redir_valid) begin
            assert (redirect.target == e.redir_target) else begin
                errors++;
                $display("ERROR %s: target expected 0x%h, actual 0x%h", e.name, e.redir_target,
                         redirect.target);
            end
        end
    endtask

    // outputs are registered, stable 1 ns after the edge.
    task automatic check_outputs();
        pending_t p;
        if (pending_q.size() > 0 && pending_q[0].due == step_cnt) begin
            p = pending_q.pop_front();
            compare_entry(table_q[p.idx]);
        end else begin
            assert (!wb.valid && !redirect.valid) else begin
                errors++;
                $display("output strobe at step %0d with no instruction expecting it", step_cnt);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge I_sys_clk);
        #1;
        step_cnt++;
        check_outputs();
    endtask

    task automatic drive_entry(input int idx);
        pending_t p;
        instr_in.valid     = 1'b1;
        instr_in.pc        = table_q[idx].pc;
        instr_in.instr     = table_q[idx].instr;
        instr_in.rs1_value = table_q[idx].rs1_value;
        p.idx = idx;
        p.due = step_cnt + 2;
        pending_q.push_back(p);
    endtask

    task automatic idle_inputs();
        instr_in = '0;
    endtask

    initial begin
        I_rst     = 1'b1;
        instr_in  = '0;
        step_cnt  = 0;
        cycle_cnt = 0;
        checks    = 0;
        errors    = 0;
        build_table();
        timeout_cycles = 2 * table_q.size() + 20;
        repeat (2) @(posedge I_sys_clk);
        #1;
        I_rst = 1'b0;
        foreach (table_q[i]) begin
            drive_entry(i);
            next_cycle();
            for (int g = 0; g < table_q[i].gap; g++) begin
                idle_inputs();
                next_cycle();
            end
        end
        idle_inputs();
        while (pending_q.size() > 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();  // no stray strobes.
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: source/csr_file.sv
`timescale 1ns/100ps
module csr_file (
    input  logic                 I_sys_clk,
    input  logic                 I_rst,
    input  csr_pkg::csr_req_t    req,
    output riscv_isa_pkg::xlen_t old_value
);
    import riscv_isa_pkg::*;
    import csr_pkg::*;

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mscratch;

    xlen_t csr_rdata;
    xlen_t csr_wdata;
    xlen_t mstatus_ret;
    logic  csr_we;
    logic  trap_we;
    logic  ret_we;

    // addressed read, unknown reads zero.
    always_comb begin
        case (req.addr)
            CSR_MSTATUS: begin
                csr_rdata = mstatus;
            end
            CSR_MTVEC: begin
                csr_rdata = mtvec;
            end
            CSR_MEPC: begin
                csr_rdata = mepc;
            end
            CSR_MCAUSE: begin
                csr_rdata = mcause;
            end
            CSR_MSCRATCH: begin
                csr_rdata = mscratch;
            end
            default: begin
                csr_rdata = '0;
            end
        endcase
    end

    // trap and return read the redirect source.
    always_comb begin
        case (req.op)
            TRAP: begin
                old_value = mtvec;
            end
            RET: begin
                old_value = mepc;
            end
            default: begin
                old_value = csr_rdata;
            end
        endcase
    end

    // read-modify-write.
    always_comb begin
        case (req.op)
            WRITE: begin
                csr_wdata = req.operand;
            end
            SET: begin
                csr_wdata = csr_rdata | req.operand;
            end
            CLEAR: begin
                csr_wdata = csr_rdata & ~req.operand;
            end
            default: begin
                csr_wdata = csr_rdata;
            end
        endcase
    end

    always_comb begin
        mstatus_ret                   = mstatus;
        mstatus_ret[MSTATUS_MIE_BIT]  = mstatus[MSTATUS_MPIE_BIT];
        mstatus_ret[MSTATUS_MPIE_BIT] = 1'b1;
    end

    assign csr_we  = req.valid && (req.op inside {WRITE, SET, CLEAR});
    assign trap_we = req.valid && (req.op == TRAP);
    assign ret_we  = req.valid && (req.op == RET);

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus  <= MSTATUS_RESET;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (csr_we) begin
            case (req.addr)
                CSR_MSTATUS:  mstatus  <= csr_wdata;
                CSR_MTVEC:    mtvec    <= csr_wdata;
                CSR_MEPC:     mepc     <= csr_wdata;
                CSR_MCAUSE:   mcause   <= csr_wdata;
                CSR_MSCRATCH: mscratch <= csr_wdata;
                default: begin
                    mscratch <= mscratch;  // unknown, write dropped.
                end
            endcase
        end else if (trap_we) begin
            mepc   <= req.pc;  // mstatus left as is.
            mcause <= req.cause;
        end else if (ret_we) begin
            mstatus <= mstatus_ret;
        end
    end

endmodule

// File: source/csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // mpp = 3, sxl/uxl = 2.
    localparam riscv_isa_pkg::xlen_t MSTATUS_RESET = 64'ha00001800;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam riscv_isa_pkg::xlen_t CAUSE_BREAKPOINT = 64'd3;
    localparam riscv_isa_pkg::xlen_t CAUSE_ECALL_M    = 64'd11;

    typedef enum logic [2:0] {
        NONE  = 3'd0,  // read only.
        WRITE = 3'd1,
        SET   = 3'd2,
        CLEAR = 3'd3,
        TRAP  = 3'd4,
        RET   = 3'd5
    } csr_op_t;

    typedef struct packed {
        logic                   valid;
        riscv_isa_pkg::xlen_t   pc;
        riscv_isa_pkg::instr_t  instr;
        riscv_isa_pkg::xlen_t   rs1_value;
    } sys_instr_t;

    typedef struct packed {
        logic                   valid;
        csr_op_t                op;
        csr_addr_t              addr;
        riscv_isa_pkg::xlen_t   operand;
        riscv_isa_pkg::xlen_t   pc;
        riscv_isa_pkg::xlen_t   cause;
        riscv_isa_pkg::reg_idx_t rd;
        logic                   wb_en;
    } csr_req_t;

    typedef struct packed {
        logic                    valid;
        riscv_isa_pkg::reg_idx_t rd;
        riscv_isa_pkg::xlen_t    value;
    } csr_wb_t;

    typedef struct packed {
        logic                 valid;
        riscv_isa_pkg::xlen_t target;
    } redirect_t;

endpackage

// File: source/csr_unit_top.sv
`timescale 1ns/100ps
module csr_unit_top (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  csr_pkg::sys_instr_t instr_in,
    output csr_pkg::csr_wb_t    wb,
    output csr_pkg::redirect_t  redirect
);
    import riscv_isa_pkg::*;
    import csr_pkg::*;

    csr_req_t req;        // registered decode result.
    xlen_t    old_value;  // combinational csr read.

    sys_instr_decode u_decode (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .instr_in  (instr_in),
        .req       (req)
    );

    csr_file u_csr_file (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .req       (req),
        .old_value (old_value)
    );

    trap_redirect u_redirect (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .req       (req),
        .old_value (old_value),
        .wb        (wb),
        .redirect  (redirect)
    );

endmodule

// File: source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // i-type layout, shared by csr and privileged forms.
    typedef struct packed {
        logic [11:0] funct12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_t;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // funct3 under SYSTEM.
    localparam logic [2:0] F3_PRIV   = 3'b000;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // funct12 for F3_PRIV.
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

endpackage

// File: source/sys_instr_decode.sv
`timescale 1ns/100ps
module sys_instr_decode (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  csr_pkg::sys_instr_t instr_in,
    output csr_pkg::csr_req_t   req
);
    import riscv_isa_pkg::*;
    import csr_pkg::*;

    instr_t   ins;
    logic     is_system;
    logic     is_csr_reg;
    logic     is_csr_imm;
    logic     is_priv;
    logic     src_zero;
    logic     known;
    xlen_t    uimm;
    csr_req_t req_d;

    assign ins       = instr_in.instr;
    assign is_system = (ins.opcode == OPCODE_SYSTEM);
    assign src_zero  = (ins.rs1 == '0);  // rs1 index or uimm, same field.
    assign uimm      = xlen_t'(ins.rs1);

    // classify by funct3.
    always_comb begin
        is_csr_reg = 1'b0;
        is_csr_imm = 1'b0;
        is_priv    = 1'b0;
        case (ins.funct3)
            F3_CSRRW, F3_CSRRS, F3_CSRRC: begin
                is_csr_reg = 1'b1;
            end
            F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: begin
                is_csr_imm = 1'b1;
            end
            F3_PRIV: begin
                is_priv = 1'b1;
            end
            default: begin
                is_csr_reg = 1'b0;  // 3'b100 is not a system form.
            end
        endcase
    end

    always_comb begin
        req_d         = '0;
        known         = is_csr_reg | is_csr_imm;
        req_d.pc      = instr_in.pc;
        req_d.addr    = ins.funct12;
        req_d.rd      = ins.rd;
        req_d.operand = is_csr_imm ? uimm : instr_in.rs1_value;
        req_d.wb_en   = (is_csr_reg | is_csr_imm) && (ins.rd != '0);
        req_d.op      = NONE;
        case (ins.funct3)
            F3_CSRRW, F3_CSRRWI: begin
                req_d.op = WRITE;
            end
            F3_CSRRS, F3_CSRRSI: begin
                req_d.op = src_zero ? NONE : SET;  // zero source, no write.
            end
            F3_CSRRC, F3_CSRRCI: begin
                req_d.op = src_zero ? NONE : CLEAR;
            end
            default: begin
                req_d.op = NONE;
            end
        endcase
        if (is_priv) begin
            case (ins.funct12)
                F12_ECALL: begin
                    known       = 1'b1;
                    req_d.op    = TRAP;
                    req_d.cause = CAUSE_ECALL_M;
                end
                F12_EBREAK: begin
                    known       = 1'b1;
                    req_d.op    = TRAP;
                    req_d.cause = CAUSE_BREAKPOINT;
                end
                F12_MRET: begin
                    known    = 1'b1;
                    req_d.op = RET;
                end
                default: begin
                    known = 1'b0;
                end
            endcase
        end
        req_d.valid = instr_in.valid && is_system && known;
    end

    always_ff @(posedge I_sys_clk) begin
        req <= req_d;
        if (I_rst) begin
            req.valid <= 1'b0;
        end
    end

endmodule

// File: source/trap_redirect.sv
`timescale 1ns/100ps
module trap_redirect (
    input  logic                 I_sys_clk,
    input  logic                 I_rst,
    input  csr_pkg::csr_req_t    req,
    input  riscv_isa_pkg::xlen_t old_value,
    output csr_pkg::csr_wb_t     wb,
    output csr_pkg::redirect_t   redirect
);
    import riscv_isa_pkg::*;
    import csr_pkg::*;

    logic  is_csr_op;
    logic  is_jump;
    logic  wb_fire;
    logic  redirect_fire;
    xlen_t target_d;

    assign is_csr_op = req.op inside {NONE, WRITE, SET, CLEAR};
    assign is_jump   = (req.op == TRAP) || (req.op == RET);

    assign wb_fire       = req.valid && is_csr_op && req.wb_en;
    assign redirect_fire = req.valid && is_jump;

    // mtvec base drops mode bits, mepc drops bit 0.
    always_comb begin
        case (req.op)
            TRAP: begin
                target_d = {old_value[63:2], 2'b00};
            end
            RET: begin
                target_d = {old_value[63:1], 1'b0};
            end
            default: begin
                target_d = old_value;
            end
        endcase
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            wb.valid       <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            wb.valid       <= wb_fire;
            redirect.valid <= redirect_fire;
        end
    end

    // payload, no reset.
    always_ff @(posedge I_sys_clk) begin
        wb.rd           <= req.rd;
        wb.value        <= old_value;
        redirect.target <= target_d;
    end

endmodule
